// ==== build.f ====
hdl/core_pkg.sv
hdl/ififo_if.sv
hdl/dispatch_if.sv
hdl/ififo.sv
hdl/decode.sv
hdl/frontend_dispatch_top.sv
verif/tb_frontend_dispatch.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_frontend_dispatch
LINT_TOP  := frontend_dispatch_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only -Wall --timing
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_frontend_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frontend_dispatch import core_pkg::*; ();

    localparam int WAIT_LIMIT = 200;  // cycles per wait loop

    typedef struct packed {
        instr_t instr;
        addr_t  pc;
        logic   is_cond_br;
        logic   br_dir_pred;
        addr_t  br_target_pred;
    } packet_t;

    typedef struct packed {
        imm_t     imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        funct3_t  funct3;
        logic     src1_valid;
        logic     src2_valid;
        logic     dst_valid;
        logic [5:0] types;  // r i s b u j
        logic     is_sub;
        logic     is_sra_srai;
        logic     is_lui;
        logic     is_jalr;
        logic     is_illegal;
    } expect_t;

    logic clk, rst_n;
    logic fetch_valid, fetch_ready, fetch_is_cond_br, fetch_br_dir_pred;
    instr_t fetch_instr;
    addr_t fetch_pc, fetch_br_target_pred;
    logic disp_valid, disp_ready;
    addr_t disp_pc, disp_br_target_pred;
    imm_t disp_imm;
    reg_idx_t disp_rs1, disp_rs2, disp_rd;
    funct3_t disp_funct3;
    logic disp_src1_valid, disp_src2_valid, disp_dst_valid;
    logic disp_is_r_type, disp_is_i_type, disp_is_s_type;
    logic disp_is_b_type, disp_is_u_type, disp_is_j_type;
    logic disp_is_sub, disp_is_sra_srai, disp_is_lui, disp_is_jalr, disp_is_illegal;
    logic disp_is_cond_br, disp_br_dir_pred;

    logic [130:0] disp_record;   // every dispatch output, for the stall check
    packet_t      sent_q[$];     // accepted, not yet dispatched
    logic [31:0]  lfsr_state;
    logic         bp_on;         // random disp_ready when set
    int           errors, timeouts, n_sent, n_disp;

    frontend_dispatch_top dut (.*);

    assign disp_record = {disp_valid, disp_pc, disp_imm, disp_rs1, disp_rs2, disp_rd,
                          disp_funct3, disp_src1_valid, disp_src2_valid, disp_dst_valid,
                          disp_is_r_type, disp_is_i_type, disp_is_s_type, disp_is_b_type,
                          disp_is_u_type, disp_is_j_type, disp_is_sub, disp_is_sra_srai,
                          disp_is_lui, disp_is_jalr, disp_is_illegal, disp_is_cond_br,
                          disp_br_dir_pred, disp_br_target_pred};

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // expected record, built from the rv32i encoding tables
    function automatic expect_t decode_ref(input instr_t ins);
        expect_t e;
        opcode_t op;
        op = ins[6:0];
        e = '0;
        e.rs1 = ins[19:15];
        e.rs2 = ins[24:20];
        e.rd = ins[11:7];
        e.funct3 = ins[14:12];
        case (op)
            OP_OPCODE: e.types = 6'b100000;
            OP_IMM_OPCODE, JALR_OPCODE: begin
                e.types = 6'b010000;
                e.imm = $signed(ins) >>> 20;
            end
            STORE_OPCODE: begin
                e.types = 6'b001000;
                e.imm = $signed({ins[31:25], ins[11:7], 20'b0}) >>> 20;
            end
            BR_OPCODE: begin
                e.types = 6'b000100;
                e.imm = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0, 19'b0}) >>> 19;
            end
            LUI_OPCODE, AUIPC_OPCODE: begin
                e.types = 6'b000010;
                e.imm = {ins[31:12], 12'h000};
            end
            JAL_OPCODE: begin
                e.types = 6'b000001;
                e.imm = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0, 11'b0}) >>> 11;
            end
            default: e.is_illegal = 1'b1;  // flags and immediate stay zero
        endcase
        e.src1_valid = e.types[5] | e.types[4] | e.types[3] | e.types[2];
        e.src2_valid = e.types[5] | e.types[3] | e.types[2];
        e.dst_valid = e.types[5] | e.types[4] | e.types[1] | e.types[0];
        e.is_sub = (op == OP_OPCODE) && (ins[14:12] == 3'b000) && ins[30];
        e.is_sra_srai = (op == OP_OPCODE || op == OP_IMM_OPCODE) &&
                        (ins[14:12] == 3'b101) && ins[30];
        e.is_lui = (op == LUI_OPCODE);
        e.is_jalr = (op == JALR_OPCODE);
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected 0x%08h got 0x%08h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic compare_record(input packet_t p, input expect_t e);
        check_value("disp_pc", p.pc, disp_pc);
        check_value("disp_imm", e.imm, disp_imm);
        check_value("disp_rs1", e.rs1, disp_rs1);
        check_value("disp_rs2", e.rs2, disp_rs2);
        check_value("disp_rd", e.rd, disp_rd);
        check_value("disp_funct3", e.funct3, disp_funct3);
        check_value("disp_src1_valid", e.src1_valid, disp_src1_valid);
        check_value("disp_src2_valid", e.src2_valid, disp_src2_valid);
        check_value("disp_dst_valid", e.dst_valid, disp_dst_valid);
        check_value("disp_is_r_type", e.types[5], disp_is_r_type);
        check_value("disp_is_i_type", e.types[4], disp_is_i_type);
        check_value("disp_is_s_type", e.types[3], disp_is_s_type);
        check_value("disp_is_b_type", e.types[2], disp_is_b_type);
        check_value("disp_is_u_type", e.types[1], disp_is_u_type);
        check_value("disp_is_j_type", e.types[0], disp_is_j_type);
        check_value("disp_is_sub", e.is_sub, disp_is_sub);
        check_value("disp_is_sra_srai", e.is_sra_srai, disp_is_sra_srai);
        check_value("disp_is_lui", e.is_lui, disp_is_lui);
        check_value("disp_is_jalr", e.is_jalr, disp_is_jalr);
        check_value("disp_is_illegal", e.is_illegal, disp_is_illegal);
        check_value("disp_is_cond_br", p.is_cond_br, disp_is_cond_br);
        check_value("disp_br_dir_pred", p.br_dir_pred, disp_br_dir_pred);
        check_value("disp_br_target_pred", p.br_target_pred, disp_br_target_pred);
    endtask

    // records accepted packets and checks each dispatched record in order
    always @(posedge clk) begin : scoreboard
        packet_t p;
        if (rst_n && fetch_valid && fetch_ready) begin
            sent_q.push_back({fetch_instr, fetch_pc, fetch_is_cond_br, fetch_br_dir_pred,
                              fetch_br_target_pred});
            n_sent++;
        end
        if (rst_n && disp_valid && disp_ready) begin
            if (sent_q.size() == 0) begin
                $display("dispatched a record with no accepted packet outstanding at %0t", $time);
                errors++;
            end else begin
                p = sent_q.pop_front();
                compare_record(p, decode_ref(p.instr));
                n_disp++;
            end
        end
    end

    task automatic next_cycle();
        logic [31:0] r;
        @(negedge clk);
        if (bp_on) begin
            rand_bits(3, r);
            disp_ready = (r[2:0] >= 3'd3);  // low 3 times in 8
        end
    endtask

    // cls 0..7 picks a supported opcode, 8 an unsupported one
    task automatic make_packet(input int cls, output packet_t p);
        logic [31:0] r;
        opcode_t op;
        rand_bits(25, r);
        p.instr[31:7] = r[24:0];
        rand_bits(2, r);
        case (cls)
            0: op = OP_OPCODE;
            1: op = OP_IMM_OPCODE;
            2: op = JALR_OPCODE;
            3: op = STORE_OPCODE;
            4: op = BR_OPCODE;
            5: op = LUI_OPCODE;
            6: op = AUIPC_OPCODE;
            7: op = JAL_OPCODE;
            default: op = (r[1:0] == 2'd0) ? 7'b0000011 :   // load
                          (r[1:0] == 2'd1) ? 7'b1110011 :   // system
                          (r[1:0] == 2'd2) ? 7'b0001111 : 7'b0101111;
        endcase
        if ((op == OP_OPCODE || op == OP_IMM_OPCODE) && r[0]) begin
            p.instr[14:12] = r[1] ? 3'b101 : 3'b000;  // steer toward sub and sra
        end
        p.instr[6:0] = op;
        rand_bits(30, r);
        p.pc = {r[29:0], 2'b00};
        rand_bits(2, r);
        p.is_cond_br = r[1];    // independent of the opcode, so passthrough is visible
        p.br_dir_pred = r[0];
        rand_bits(31, r);
        p.br_target_pred = {r[30:0], 1'b0};
    endtask

    // returns on the falling edge after the acceptance edge
    task automatic send_packet(input packet_t p);
        int waited;
        fetch_instr = p.instr;
        fetch_pc = p.pc;
        fetch_is_cond_br = p.is_cond_br;
        fetch_br_dir_pred = p.br_dir_pred;
        fetch_br_target_pred = p.br_target_pred;
        fetch_valid = 1'b1;
        waited = 0;
        while (!fetch_ready && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!fetch_ready) begin
            $display("timeout: fetch_ready stayed low for %0d cycles", waited);
            timeouts++;
        end
        next_cycle();
        fetch_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (sent_q.size() != 0 && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (sent_q.size() != 0) begin
            $display("timeout: %0d packets never reached dispatch", sent_q.size());
            timeouts++;
        end
    endtask

    initial begin
        packet_t pkt;
        logic [130:0] held;
        logic [31:0] r;
        int lat;
        clk = 1'b0;
        rst_n = 1'b0;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        fetch_pc = '0;
        fetch_is_cond_br = 1'b0;
        fetch_br_dir_pred = 1'b0;
        fetch_br_target_pred = '0;
        disp_ready = 1'b0;
        bp_on = 1'b0;
        lfsr_state = 32'hf00d_eb40;
        errors = 0;
        timeouts = 0;
        n_sent = 0;
        n_disp = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        next_cycle();
        check_value("disp_valid", 0, disp_valid);   // idle after reset
        check_value("fetch_ready", 1, fetch_ready);

        // single packet through an idle pipeline
        disp_ready = 1'b1;
        make_packet(1, pkt);
        send_packet(pkt);
        lat = 1;
        while (!disp_valid && lat < WAIT_LIMIT) begin
            next_cycle();
            lat++;
        end
        if (!disp_valid) begin
            $display("timeout: disp_valid never rose after a single push");
            timeouts++;
        end
        check_value("fetch_to_disp_latency", 2, lat);
        wait_drain();

        for (int k = 0; k < 72; k++) begin   // every opcode class, back to back
            make_packet(k % 9, pkt);
            send_packet(pkt);
        end
        wait_drain();

        // stall with five in flight
        disp_ready = 1'b0;
        for (int k = 0; k < 5; k++) begin
            make_packet(k, pkt);
            send_packet(pkt);
        end
        check_value("fetch_ready", 0, fetch_ready);
        held = disp_record;
        check_value("disp_valid", 1, disp_valid);
        repeat (6) begin
            next_cycle();
            if (disp_record !== held) begin
                $display("[FAIL] disp_record expected 0x%033h got 0x%033h", held, disp_record);
                errors++;
            end
            check_value("fetch_ready", 0, fetch_ready);
        end
        disp_ready = 1'b1;
        wait_drain();

        // random gaps and random back-pressure
        bp_on = 1'b1;
        repeat (300) begin
            rand_bits(3, r);
            if (r[2:1] == 2'd0) begin
                repeat (int'(r[0]) + 1) next_cycle();
            end
            rand_bits(4, r);
            make_packet(int'(r[3:0]) % 9, pkt);
            send_packet(pkt);
        end
        bp_on = 1'b0;
        disp_ready = 1'b1;
        wait_drain();

        if (n_sent != n_disp) begin
            $display("accepted %0d packets but dispatched %0d", n_sent, n_disp);
            errors++;
        end
        $display("errors: %0d, timeouts: %0d, accepted: %0d, dispatched: %0d",
                 errors, timeouts, n_sent, n_disp);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/frontend_dispatch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_dispatch_top import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetch_valid,
    output logic     fetch_ready,
    input  instr_t   fetch_instr,
    input  addr_t    fetch_pc,
    input  logic     fetch_is_cond_br,
    input  logic     fetch_br_dir_pred,
    input  addr_t    fetch_br_target_pred,
    output logic     disp_valid,
    input  logic     disp_ready,
    output addr_t    disp_pc,
    output imm_t     disp_imm,
    output reg_idx_t disp_rs1,
    output reg_idx_t disp_rs2,
    output reg_idx_t disp_rd,
    output funct3_t  disp_funct3,
    output logic     disp_src1_valid,
    output logic     disp_src2_valid,
    output logic     disp_dst_valid,
    output logic     disp_is_r_type,
    output logic     disp_is_i_type,
    output logic     disp_is_s_type,
    output logic     disp_is_b_type,
    output logic     disp_is_u_type,
    output logic     disp_is_j_type,
    output logic     disp_is_sub,
    output logic     disp_is_sra_srai,
    output logic     disp_is_lui,
    output logic     disp_is_jalr,
    output logic     disp_is_illegal,
    output logic     disp_is_cond_br,
    output logic     disp_br_dir_pred,
    output addr_t    disp_br_target_pred
);

    ififo_if    ififo_bus ();   // fifo head to decode
    dispatch_if disp_bus ();    // decode register to dispatch ports

    ififo u_ififo (
        .clk                 (clk),
        .rst_n               (rst_n),
        .push_valid          (fetch_valid),
        .push_ready          (fetch_ready),
        .push_instr          (fetch_instr),
        .push_pc             (fetch_pc),
        .push_is_cond_br     (fetch_is_cond_br),
        .push_br_dir_pred    (fetch_br_dir_pred),
        .push_br_target_pred (fetch_br_target_pred),
        .deq                 (ififo_bus.fifo_side)
    );

    decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .enq   (ififo_bus.decode_side),
        .disp  (disp_bus.decode_side)
    );

    assign disp_bus.ready      = disp_ready;
    assign disp_valid          = disp_bus.valid;
    assign disp_pc             = disp_bus.pc;
    assign disp_imm            = disp_bus.imm;
    assign disp_rs1            = disp_bus.rs1;
    assign disp_rs2            = disp_bus.rs2;
    assign disp_rd             = disp_bus.rd;
    assign disp_funct3         = disp_bus.funct3;
    assign disp_src1_valid     = disp_bus.src1_valid;
    assign disp_src2_valid     = disp_bus.src2_valid;
    assign disp_dst_valid      = disp_bus.dst_valid;
    assign disp_is_r_type      = disp_bus.is_r_type;
    assign disp_is_i_type      = disp_bus.is_i_type;
    assign disp_is_s_type      = disp_bus.is_s_type;
    assign disp_is_b_type      = disp_bus.is_b_type;
    assign disp_is_u_type      = disp_bus.is_u_type;
    assign disp_is_j_type      = disp_bus.is_j_type;
    assign disp_is_sub         = disp_bus.is_sub;
    assign disp_is_sra_srai    = disp_bus.is_sra_srai;
    assign disp_is_lui         = disp_bus.is_lui;
    assign disp_is_jalr        = disp_bus.is_jalr;
    assign disp_is_illegal     = disp_bus.is_illegal;
    assign disp_is_cond_br     = disp_bus.is_cond_br;
    assign disp_br_dir_pred    = disp_bus.br_dir_pred;
    assign disp_br_target_pred = disp_bus.br_target_pred;

endmodule

`default_nettype wire

// ==== hdl/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode import core_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    ififo_if.decode_side    enq,
    dispatch_if.decode_side disp
);

    opcode_t opcode;
    funct3_t funct3;
    logic    bit30;     // funct7[5], picks sub and sra

    logic r_type;
    logic i_type;
    logic s_type;
    logic b_type;
    logic u_type;
    logic j_type;
    logic illegal;
    imm_t imm;
    logic load;

    assign opcode = enq.instr[6:0];
    assign funct3 = enq.instr[14:12];
    assign bit30  = enq.instr[30];

    assign r_type  = (opcode == OP_OPCODE);
    assign i_type  = (opcode == OP_IMM_OPCODE) || (opcode == JALR_OPCODE);
    assign s_type  = (opcode == STORE_OPCODE);
    assign b_type  = (opcode == BR_OPCODE);
    assign u_type  = (opcode == LUI_OPCODE) || (opcode == AUIPC_OPCODE);
    assign j_type  = (opcode == JAL_OPCODE);
    assign illegal = !(r_type || i_type || s_type || b_type || u_type || j_type);

    always_comb begin
        unique case (1'b1)
            i_type:  imm = i_imm(enq.instr);
            s_type:  imm = s_imm(enq.instr);
            b_type:  imm = b_imm(enq.instr);
            u_type:  imm = u_imm(enq.instr);
            j_type:  imm = j_imm(enq.instr);
            default: imm = '0;  // r-type and illegal
        endcase
    end

    // register takes a new record when empty or draining this cycle
    assign enq.ready = !disp.valid || disp.ready;
    assign load      = enq.valid && enq.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            disp.valid <= 1'b0;
        end else if (enq.ready) begin
            disp.valid <= enq.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            disp.pc             <= enq.pc;
            disp.imm            <= imm;
            disp.rs1            <= enq.instr[19:15];
            disp.rs2            <= enq.instr[24:20];
            disp.rd             <= enq.instr[11:7];
            disp.funct3         <= funct3;
            disp.src1_valid     <= r_type || i_type || s_type || b_type;
            disp.src2_valid     <= r_type || s_type || b_type;
            disp.dst_valid      <= r_type || i_type || u_type || j_type;
            disp.is_r_type      <= r_type;
            disp.is_i_type      <= i_type;
            disp.is_s_type      <= s_type;
            disp.is_b_type      <= b_type;
            disp.is_u_type      <= u_type;
            disp.is_j_type      <= j_type;
            disp.is_sub         <= r_type && (funct3 == SUB_FUNCT3) && bit30;
            disp.is_sra_srai    <= (opcode == OP_OPCODE || opcode == OP_IMM_OPCODE) &&
                                   (funct3 == SRA_FUNCT3) && bit30;
            disp.is_lui         <= (opcode == LUI_OPCODE);
            disp.is_jalr        <= (opcode == JALR_OPCODE);
            disp.is_illegal     <= illegal;
            disp.is_cond_br     <= enq.is_cond_br;
            disp.br_dir_pred    <= enq.br_dir_pred;
            disp.br_target_pred <= enq.br_target_pred;
        end
    end

    one_type_per_record: assert property (
        @(posedge clk) disable iff (!rst_n)
        disp.valid |-> $onehot0({disp.is_r_type, disp.is_i_type, disp.is_s_type,
                                 disp.is_b_type, disp.is_u_type, disp.is_j_type})
    );

    // a stalled record must not change under back-pressure
    record_held_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (disp.valid && !disp.ready) |=> disp.valid &&
            $stable({disp.pc, disp.imm, disp.rs1, disp.rs2, disp.rd, disp.funct3,
                     disp.src1_valid, disp.src2_valid, disp.dst_valid,
                     disp.is_r_type, disp.is_i_type, disp.is_s_type,
                     disp.is_b_type, disp.is_u_type, disp.is_j_type,
                     disp.is_sub, disp.is_sra_srai, disp.is_lui, disp.is_jalr,
                     disp.is_illegal, disp.is_cond_br, disp.br_dir_pred,
                     disp.br_target_pred})
    );

endmodule

`default_nettype wire

// ==== hdl/ififo.sv ====
`timescale 1ns/1ps
`default_nettype none

module ififo import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   push_valid,
    output logic   push_ready,
    input  instr_t push_instr,
    input  addr_t  push_pc,
    input  logic   push_is_cond_br,
    input  logic   push_br_dir_pred,
    input  addr_t  push_br_target_pred,
    ififo_if.fifo_side deq
);

    instr_t instr_mem     [IFIFO_DEPTH];
    addr_t  pc_mem        [IFIFO_DEPTH];
    logic   cond_br_mem   [IFIFO_DEPTH];
    logic   dir_pred_mem  [IFIFO_DEPTH];
    addr_t  tgt_pred_mem  [IFIFO_DEPTH];

    ififo_ptr_t wr_ptr;
    ififo_ptr_t rd_ptr;
    logic       full;
    logic       empty;
    logic       push;
    logic       pop;

    logic [IFIFO_IDX_W-1:0] wr_idx;
    logic [IFIFO_IDX_W-1:0] rd_idx;

    assign wr_idx = wr_ptr[IFIFO_IDX_W-1:0];
    assign rd_idx = rd_ptr[IFIFO_IDX_W-1:0];

    // same slot, different lap means full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_idx == rd_idx) && (wr_ptr[IFIFO_IDX_W] != rd_ptr[IFIFO_IDX_W]);

    assign push_ready = !full;
    assign push       = push_valid && push_ready;
    assign pop        = deq.valid && deq.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            instr_mem[wr_idx]    <= push_instr;
            pc_mem[wr_idx]       <= push_pc;
            cond_br_mem[wr_idx]  <= push_is_cond_br;
            dir_pred_mem[wr_idx] <= push_br_dir_pred;
            tgt_pred_mem[wr_idx] <= push_br_target_pred;
        end
    end

    // head entry is presented straight out of the array
    assign deq.valid          = !empty;
    assign deq.instr          = instr_mem[rd_idx];
    assign deq.pc             = pc_mem[rd_idx];
    assign deq.is_cond_br     = cond_br_mem[rd_idx];
    assign deq.br_dir_pred    = dir_pred_mem[rd_idx];
    assign deq.br_target_pred = tgt_pred_mem[rd_idx];

    wr_hold_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        full |=> (wr_ptr == $past(wr_ptr))
    );

    rd_hold_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        empty |=> (rd_ptr == $past(rd_ptr))
    );

endmodule

`default_nettype wire

// ==== hdl/dispatch_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dispatch_if import core_pkg::*; ();

    logic     valid;
    logic     ready;
    addr_t    pc;
    imm_t     imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    funct3_t  funct3;
    logic     src1_valid;   // operand exists, not operand ready
    logic     src2_valid;
    logic     dst_valid;
    logic     is_r_type;
    logic     is_i_type;
    logic     is_s_type;
    logic     is_b_type;
    logic     is_u_type;
    logic     is_j_type;
    logic     is_sub;
    logic     is_sra_srai;
    logic     is_lui;       // lui vs auipc within u-type
    logic     is_jalr;      // jalr vs op-imm within i-type
    logic     is_illegal;
    logic     is_cond_br;
    logic     br_dir_pred;
    addr_t    br_target_pred;

    modport decode_side (
        output valid, pc, imm, rs1, rs2, rd, funct3,
        output src1_valid, src2_valid, dst_valid,
        output is_r_type, is_i_type, is_s_type, is_b_type, is_u_type, is_j_type,
        output is_sub, is_sra_srai, is_lui, is_jalr, is_illegal,
        output is_cond_br, br_dir_pred, br_target_pred,
        input  ready
    );

    modport top_side (
        input  valid, pc, imm, rs1, rs2, rd, funct3,
        input  src1_valid, src2_valid, dst_valid,
        input  is_r_type, is_i_type, is_s_type, is_b_type, is_u_type, is_j_type,
        input  is_sub, is_sra_srai, is_lui, is_jalr, is_illegal,
        input  is_cond_br, br_dir_pred, br_target_pred,
        output ready
    );

endinterface

`default_nettype wire

// ==== hdl/ififo_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ififo_if import core_pkg::*; ();

    logic   valid;          // fifo not empty
    logic   ready;          // decode can take the head
    instr_t instr;
    addr_t  pc;
    logic   is_cond_br;
    logic   br_dir_pred;    // 1 = predicted taken
    addr_t  br_target_pred;

    modport fifo_side (
        output valid, instr, pc, is_cond_br, br_dir_pred, br_target_pred,
        input  ready
    );

    modport decode_side (
        input  valid, instr, pc, is_cond_br, br_dir_pred, br_target_pred,
        output ready
    );

endinterface

`default_nettype wire

// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;     // pc and predicted targets
    typedef logic [31:0]     instr_t;    // raw rv32i word
    typedef logic [XLEN-1:0] imm_t;      // sign-extended immediate
    typedef logic [4:0]      reg_idx_t;  // architectural register index
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      opcode_t;

    localparam int IFIFO_DEPTH = 4;
    localparam int IFIFO_IDX_W = $clog2(IFIFO_DEPTH);

    typedef logic [IFIFO_IDX_W:0] ififo_ptr_t; // msb is the wrap bit

    localparam opcode_t OP_OPCODE     = 7'b0110011;
    localparam opcode_t OP_IMM_OPCODE = 7'b0010011;
    localparam opcode_t LUI_OPCODE    = 7'b0110111;
    localparam opcode_t AUIPC_OPCODE  = 7'b0010111;
    localparam opcode_t BR_OPCODE     = 7'b1100011;
    localparam opcode_t JAL_OPCODE    = 7'b1101111;
    localparam opcode_t JALR_OPCODE   = 7'b1100111;
    localparam opcode_t STORE_OPCODE  = 7'b0100011;

    localparam funct3_t SUB_FUNCT3 = 3'b000; // add / sub
    localparam funct3_t SRA_FUNCT3 = 3'b101; // srl(i) / sra(i)

    function automatic imm_t i_imm(input instr_t instr);
        return {{(XLEN-12){instr[31]}}, instr[31:20]};
    endfunction

    function automatic imm_t s_imm(input instr_t instr);
        return {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    endfunction

    // branch offsets are always even
    function automatic imm_t b_imm(input instr_t instr);
        return {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                instr[11:8], 1'b0};
    endfunction

    function automatic imm_t u_imm(input instr_t instr);
        return {{(XLEN-32){instr[31]}}, instr[31:12], 12'b0};
    endfunction

    function automatic imm_t j_imm(input instr_t instr);
        return {{(XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                instr[30:21], 1'b0};
    endfunction

endpackage

`default_nettype wire
